/* source/flashBootPkg.sv */
package flashBootPkg;

  // image geometry
  localparam int imageWords = 16;
  localparam int imageBytes = 4 * imageWords;
  localparam int wordIndexBits = $clog2(imageWords);
  localparam int byteIndexBits = $clog2(imageBytes);

  // standard SPI NOR read, no dummy cycles
  localparam logic [7:0] readCommand = 8'h03;

  // serial frame lengths, command plus 24-bit address then data
  localparam int headerBits = 32;
  localparam int receiveBits = imageBytes * 8;
  localparam int bitCountBits = $clog2(receiveBits);

  // counter compare values
  localparam logic [bitCountBits-1:0] lastHeaderBit = bitCountBits'(headerBits - 1);
  localparam logic [bitCountBits-1:0] lastReceiveBit = bitCountBits'(receiveBits - 1);
  localparam logic [bitCountBits-1:0] lastTailCycle = bitCountBits'(1);
  localparam logic [byteIndexBits:0] fullByteCount = (byteIndexBits + 1)'(imageBytes);

  // one received byte and its position in the image
  typedef struct packed {
    logic [7:0] data;
    logic [byteIndexBits-1:0] index;
  } imageByte;

  // registered answer to a fetch strobe
  typedef struct packed {
    logic [31:0] word;
    logic valid;
    logic error;
  } fetchResult;

endpackage

/* source/spiFlashReader.sv */
module spiFlashReader (
  input  logic clock,
  input  logic rstN,
  input  logic bootStart,
  input  logic [23:0] bootAddress,
  input  logic flashMiso,
  output logic flashClk,
  output logic flashMosi,
  output logic flashCs,
  output logic loadStart,
  output logic byteWrite,
  output flashBootPkg::imageByte byteOut,
  output logic bootBusy,
  output logic bootDone
);

  typedef enum logic [1:0] {
    stateIdle,
    stateSend,
    stateReceive,
    stateDone
  } readerState;

  readerState state;
  logic phase;
  logic [flashBootPkg::bitCountBits-1:0] bitCount;
  logic [31:0] shiftReg;
  logic [6:0] rxShift;
  logic startAccepted;
  logic sampleEdge;

  // starts are dropped unless the reader is idle
  assign startAccepted = (state == stateIdle) && bootStart;

  // phase high means flashClk is high in this cycle
  assign sampleEdge = (state == stateReceive) && phase;

  assign flashClk = phase;
  // MSB first, only while the header is going out
  assign flashMosi = (state == stateSend) && shiftReg[31];
  assign bootBusy = (state != stateIdle);

  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      state <= stateIdle;
      phase <= 1'b0;
      bitCount <= '0;
      flashCs <= 1'b1;
      loadStart <= 1'b0;
      byteWrite <= 1'b0;
      bootDone <= 1'b0;
    end else begin
      loadStart <= 1'b0;
      byteWrite <= 1'b0;
      case (state)
        stateIdle: begin
          if (bootStart) begin
            state <= stateSend;
            phase <= 1'b0;
            bitCount <= '0;
            flashCs <= 1'b0;
            loadStart <= 1'b1;
            bootDone <= 1'b0;
          end
        end

        stateSend: begin
          phase <= ~phase;
          // a bit is finished at the end of its high phase
          if (phase) begin
            if (bitCount == flashBootPkg::lastHeaderBit) begin
              state <= stateReceive;
              bitCount <= '0;
            end else begin
              bitCount <= bitCount + 1'b1;
            end
          end
        end

        stateReceive: begin
          phase <= ~phase;
          if (phase) begin
            // every eighth sample completes a byte
            if (bitCount[2:0] == 3'd7) begin
              byteWrite <= 1'b1;
            end
            if (bitCount == flashBootPkg::lastReceiveBit) begin
              state <= stateDone;
              bitCount <= '0;
              flashCs <= 1'b1;
            end else begin
              bitCount <= bitCount + 1'b1;
            end
          end
        end

        stateDone: begin
          // short tail so the last byte lands before bootDone
          if (bitCount == flashBootPkg::lastTailCycle) begin
            state <= stateIdle;
            bitCount <= '0;
            bootDone <= 1'b1;
          end else begin
            bitCount <= bitCount + 1'b1;
          end
        end

        default: begin
          state <= stateIdle;
        end
      endcase
    end
  end

  // data path, command and address out, bytes in
  always_ff @(posedge clock) begin
    if (startAccepted) begin
      shiftReg <= {flashBootPkg::readCommand, bootAddress};
    end else if ((state == stateSend) && phase) begin
      shiftReg <= {shiftReg[30:0], 1'b0};
    end

    if (sampleEdge) begin
      rxShift <= {rxShift[5:0], flashMiso};
      if (bitCount[2:0] == 3'd7) begin
        byteOut <= '{
          data: {rxShift, flashMiso},
          index: bitCount[flashBootPkg::bitCountBits-1:3]
        };
      end
    end
  end

endmodule

/* source/bootImageBuffer.sv */
module bootImageBuffer (
  input  logic clock,
  input  logic rstN,
  input  logic loadStart,
  input  logic byteWrite,
  input  flashBootPkg::imageByte byteIn,
  input  logic [flashBootPkg::wordIndexBits-1:0] readIndex,
  output logic [31:0] readWord,
  output logic imageLoaded
);

  logic [31:0] words [flashBootPkg::imageWords];
  logic [flashBootPkg::byteIndexBits:0] byteCount;
  logic [flashBootPkg::wordIndexBits-1:0] writeWord;
  logic [1:0] writeLane;
  logic [4:0] laneBase;

  assign writeWord = byteIn.index[flashBootPkg::byteIndexBits-1:2];
  assign writeLane = byteIn.index[1:0];

  // big endian, lane 0 lands in bits 31:24
  assign laneBase = {~writeLane, 3'b000};

  always_ff @(posedge clock) begin
    if (byteWrite) begin
      words[writeWord][laneBase +: 8] <= byteIn.data;
    end
  end

  // combinational read for the fetch port
  assign readWord = words[readIndex];

  // received bytes since the last load started
  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      byteCount <= '0;
    end else if (loadStart) begin
      byteCount <= '0;
    end else if (byteWrite && !imageLoaded) begin
      byteCount <= byteCount + 1'b1;
    end
  end

  assign imageLoaded = (byteCount == flashBootPkg::fullByteCount);

endmodule

/* source/instructionFetch.sv */
module instructionFetch (
  input  logic clock,
  input  logic rstN,
  input  logic fetch,
  input  logic [31:0] pc,
  input  logic imageLoaded,
  input  logic [31:0] readWord,
  output logic [flashBootPkg::wordIndexBits-1:0] readIndex,
  output flashBootPkg::fetchResult fetchOut
);

  logic inRange;
  logic fetchOk;
  logic validQ;
  logic errorQ;
  logic [31:0] wordQ;

  // byte address to word index, low two bits dropped
  assign readIndex = pc[flashBootPkg::wordIndexBits+1:2];

  // anything above the index means past the end of the image
  assign inRange = ~|pc[31:flashBootPkg::wordIndexBits+2];
  assign fetchOk = fetch && imageLoaded && inRange;

  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      validQ <= 1'b0;
      errorQ <= 1'b0;
    end else begin
      validQ <= fetchOk;
      errorQ <= fetch && !fetchOk;
    end
  end

  // zero word on error or when idle
  always_ff @(posedge clock) begin
    wordQ <= fetchOk ? readWord : '0;
  end

  assign fetchOut = '{word: wordQ, valid: validQ, error: errorQ};

endmodule

/* source/flashBootTop.sv */
module flashBootTop (
  input  logic clock,
  input  logic rstN,
  input  logic bootStart,
  input  logic [23:0] bootAddress,
  input  logic fetch,
  input  logic [31:0] pc,
  input  logic flashMiso,
  output logic flashClk,
  output logic flashMosi,
  output logic flashCs,
  output logic bootBusy,
  output logic bootDone,
  output flashBootPkg::fetchResult fetchOut
);

  logic loadStart;
  logic byteWrite;
  flashBootPkg::imageByte imageData;
  logic imageLoaded;
  logic [flashBootPkg::wordIndexBits-1:0] readIndex;
  logic [31:0] readWord;

  spiFlashReader u_reader (
    .clock      (clock),
    .rstN       (rstN),
    .bootStart  (bootStart),
    .bootAddress(bootAddress),
    .flashMiso  (flashMiso),
    .flashClk   (flashClk),
    .flashMosi  (flashMosi),
    .flashCs    (flashCs),
    .loadStart  (loadStart),
    .byteWrite  (byteWrite),
    .byteOut    (imageData),
    .bootBusy   (bootBusy),
    .bootDone   (bootDone)
  );

  bootImageBuffer u_buffer (
    .clock      (clock),
    .rstN       (rstN),
    .loadStart  (loadStart),
    .byteWrite  (byteWrite),
    .byteIn     (imageData),
    .readIndex  (readIndex),
    .readWord   (readWord),
    .imageLoaded(imageLoaded)
  );

  instructionFetch u_fetch (
    .clock      (clock),
    .rstN       (rstN),
    .fetch      (fetch),
    .pc         (pc),
    .imageLoaded(imageLoaded),
    .readWord   (readWord),
    .readIndex  (readIndex),
    .fetchOut   (fetchOut)
  );

endmodule

/* sim/spiFlashModel.sv */
module spiFlashModel (
  input  logic flashClk,
  input  logic flashMosi,
  input  logic flashCs,
  output logic flashMiso
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int memBytes = 256;
  localparam int headerLength = 32;

  logic [7:0] memory [memBytes];

  // last command and address seen, read by the testbench
  logic [7:0] commandSeen = 8'h00;
  logic [23:0] addressSeen = 24'h000000;
  int transfers = 0;

  logic [31:0] header = 32'h0;
  int headerBits = 0;
  int dataBits = 0;
  logic [7:0] byteAddress;
  logic [2:0] bitIndex;
  logic misoBit = 1'b0;

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
  endfunction

  initial begin : fillMemory
    logic [31:0] lfsr;
    logic [7:0] value;
    lfsr = 32'h34e4;
    for (int i = 0; i < memBytes; i++) begin
      value = 8'h00;
      // one step per bit, msb first
      for (int b = 0; b < 8; b++) begin
        lfsr = lfsrStep(lfsr);
        value = {value[6:0], lfsr[0]};
      end
      memory[i] = value;
    end
  end

  // command and address come in on rising edges
  always @(negedge flashCs or posedge flashClk) begin
    if (!flashClk) begin
      // chip select just fell, new transfer
      headerBits = 0;
      transfers = transfers + 1;
    end else if (!flashCs && headerBits < headerLength) begin
      header = {header[30:0], flashMosi};
      headerBits = headerBits + 1;
      if (headerBits == headerLength) begin
        commandSeen = header[31:24];
        addressSeen = header[23:0];
      end
    end
  end

  // mode 0, data changes on falling edges
  always @(negedge flashClk) begin
    if (!flashCs && headerBits == headerLength && commandSeen == 8'h03) begin
      byteAddress = addressSeen[7:0] + 8'(dataBits / 8);
      bitIndex = 3'(7 - dataBits % 8);
      misoBit <= memory[byteAddress][bitIndex];
      dataBits = dataBits + 1;
    end else begin
      dataBits = 0;
    end
  end

  assign flashMiso = misoBit;

endmodule

/* sim/flashBootTb.sv */
module flashBootTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int clockPeriod = 10;
  localparam int resetCycles = 10;
  localparam int bootCycles = 2 * (32 + 8 * flashBootPkg::imageBytes) + 3;
  localparam int cycleLimit = 3 * bootCycles + 2000;

  logic clock;
  logic rstN;
  logic bootStart;
  logic [23:0] bootAddress;
  logic fetch;
  logic [31:0] pc;
  logic flashMiso;
  logic flashClk;
  logic flashMosi;
  logic flashCs;
  logic bootBusy;
  logic bootDone;
  flashBootPkg::fetchResult fetchOut;

  flashBootPkg::fetchResult expectedQueue[$];
  logic imageReady;
  logic [23:0] loadedAddress;
  int mainChecks;
  int mainErrors;
  int fetchChecks;
  int fetchErrors;
  int cycleCount;

  flashBootTop u_dut (
    .clock      (clock),
    .rstN       (rstN),
    .bootStart  (bootStart),
    .bootAddress(bootAddress),
    .fetch      (fetch),
    .pc         (pc),
    .flashMiso  (flashMiso),
    .flashClk   (flashClk),
    .flashMosi  (flashMosi),
    .flashCs    (flashCs),
    .bootBusy   (bootBusy),
    .bootDone   (bootDone),
    .fetchOut   (fetchOut)
  );

  spiFlashModel u_flash (
    .flashClk (flashClk),
    .flashMosi(flashMosi),
    .flashCs  (flashCs),
    .flashMiso(flashMiso)
  );

  initial begin
    clock = 1'b0;
    forever begin
      #(clockPeriod / 2) clock = ~clock;
    end
  end

  // expected answer from the flash contents, lowest address in bits 31:24
  function automatic flashBootPkg::fetchResult expectedFetch(
    input logic [23:0] address,
    input logic [31:0] fetchPc,
    input logic loaded
  );
    flashBootPkg::fetchResult result;
    logic [7:0] base;
    result = '0;
    if (!loaded || fetchPc >= 32'(4 * flashBootPkg::imageWords)) begin
      result.error = 1'b1;
    end else begin
      base = address[7:0] + {fetchPc[7:2], 2'b00};
      result.word = {u_flash.memory[base], u_flash.memory[base + 8'd1],
                     u_flash.memory[base + 8'd2], u_flash.memory[base + 8'd3]};
      result.valid = 1'b1;
    end
    return result;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    mainChecks++;
    assert (actual === expected) else begin
      mainErrors++;
      $display("** Error at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
    end
  endtask

  task automatic issueFetch(input logic [31:0] address);
    fetch = 1'b1;
    pc = address;
    @(negedge clock);
  endtask

  task automatic endFetches();
    fetch = 1'b0;
    pc = '0;
    repeat (2) @(negedge clock);
  endtask

  task automatic checkResetState();
    checkValue("flashCs", 32'(flashCs), 32'd1);
    checkValue("flashClk", 32'(flashClk), 32'd0);
    checkValue("flashMosi", 32'(flashMosi), 32'd0);
    checkValue("bootBusy", 32'(bootBusy), 32'd0);
    checkValue("bootDone", 32'(bootDone), 32'd0);
    checkValue("fetchOut.valid", 32'(fetchOut.valid), 32'd0);
    checkValue("fetchOut.error", 32'(fetchOut.error), 32'd0);
  endtask

  task automatic runBoot(input logic [23:0] address, input logic startWhileBusy);
    int cycles;
    int transfersBefore;
    transfersBefore = u_flash.transfers;
    imageReady = 1'b0;
    bootAddress = address;
    bootStart = 1'b1;
    @(negedge clock);
    bootStart = 1'b0;
    cycles = 1;
    checkValue("bootBusy", 32'(bootBusy), 32'd1);
    checkValue("bootDone", 32'(bootDone), 32'd0);
    while (!bootDone) begin
      // a second start in the middle of the transfer must be dropped
      if (startWhileBusy && cycles == 300) begin
        checkValue("bootBusy", 32'(bootBusy), 32'd1);
        bootAddress = address + 24'h000040;
        bootStart = 1'b1;
      end else begin
        bootStart = 1'b0;
      end
      @(negedge clock);
      cycles++;
    end
    checkValue("boot cycles", 32'(cycles), 32'(bootCycles));
    checkValue("bootBusy", 32'(bootBusy), 32'd0);
    checkValue("flashCs", 32'(flashCs), 32'd1);
    checkValue("flash command", 32'(u_flash.commandSeen), 32'h03);
    checkValue("flash address", 32'(u_flash.addressSeen), 32'(address));
    checkValue("flash transfers", 32'(u_flash.transfers - transfersBefore), 32'd1);
    loadedAddress = address;
    imageReady = 1'b1;
  endtask

  task automatic readImage();
    for (int i = 0; i < flashBootPkg::imageWords; i++) begin
      issueFetch(32'(4 * i));
    end
    // and backwards, still one per cycle
    for (int i = flashBootPkg::imageWords - 1; i >= 0; i--) begin
      issueFetch(32'(4 * i));
    end
    endFetches();
  endtask

  task automatic checkRange();
    issueFetch(32'h0000_0040);
    issueFetch(32'h0000_0043);
    issueFetch(32'h0000_0100);
    issueFetch(32'h8000_0004);
    issueFetch(32'hffff_fffc);
    // low pc bits select nothing
    issueFetch(32'h0000_0005);
    issueFetch(32'h0000_0006);
    issueFetch(32'h0000_0007);
    issueFetch(32'h0000_003f);
    endFetches();
  endtask

  // strobe captured at the rising edge, answer checked at the falling edge
  initial begin : compareFetches
    flashBootPkg::fetchResult expected;
    fetchChecks = 0;
    fetchErrors = 0;
    forever begin
      @(posedge clock);
      if (fetch) begin
        expectedQueue.push_back(expectedFetch(loadedAddress, pc, imageReady));
      end
      @(negedge clock);
      if (expectedQueue.size() != 0) begin
        expected = expectedQueue.pop_front();
        fetchChecks++;
        assert (fetchOut === expected) else begin
          fetchErrors++;
          $display("** Error at %0t: fetchOut is word %h valid %b error %b, %s %h %s %b %s %b",
                   $time, fetchOut.word, fetchOut.valid, fetchOut.error, "expected word",
                   expected.word, "valid", expected.valid, "error", expected.error);
        end
      end else begin
        assert (!fetchOut.valid && !fetchOut.error) else begin
          fetchErrors++;
          $display("fetchOut answered at %0t although no fetch was issued", $time);
        end
      end
    end
  end

  initial begin : watchdog
    cycleCount = 0;
    while (cycleCount < cycleLimit) begin
      @(posedge clock);
      cycleCount++;
    end
    $display("timeout after %0d cycles, the run did not finish", cycleCount);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    rstN = 1'b0;
    bootStart = 1'b0;
    bootAddress = '0;
    fetch = 1'b0;
    pc = '0;
    imageReady = 1'b0;
    loadedAddress = '0;
    mainChecks = 0;
    mainErrors = 0;
    repeat (resetCycles) @(negedge clock);
    rstN = 1'b1;
    @(negedge clock);
    checkResetState();

    // no image yet
    issueFetch(32'h0000_0000);
    issueFetch(32'h0000_0010);
    endFetches();

    runBoot(24'h000000, 1'b0);
    readImage();
    checkRange();

    runBoot(24'h000040, 1'b1);
    readImage();
    issueFetch(32'h0000_0024);
    issueFetch(32'h0000_0024);
    issueFetch(32'h0000_0026);
    endFetches();

    assert (expectedQueue.size() == 0) else begin
      mainErrors++;
      $display("%0d fetch strobes never got an answer", expectedQueue.size());
    end
    $display("checks %0d, errors %0d (fetch errors %0d, other errors %0d)",
             mainChecks + fetchChecks, mainErrors + fetchErrors, fetchErrors, mainErrors);
    if (mainErrors + fetchErrors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* tb.f */
source/flashBootPkg.sv
source/spiFlashReader.sv
source/bootImageBuffer.sv
source/instructionFetch.sv
source/flashBootTop.sv
sim/spiFlashModel.sv
sim/flashBootTb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = flashBootTb
FILELIST = tb.f

BUILD    = obj_dir
BINARY   = $(BUILD)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BINARY): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BINARY)
	./$(BINARY) | tee $(LOG)
	@if grep -q 'STATUS: FAIL' $(LOG) || ! grep -q 'STATUS: PASS' $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
